//--- net_pkg.sv
// shared widths, id types and channel packets for the L2 to directory network
// modules pull this in by wildcard import, ports use scoped names
`default_nettype none

package net_pkg;

  localparam int NID_W  = 2;  // four L2 ports
  localparam int NUM_DR = 2;  // directories, fixed

  typedef logic [NID_W-1:0]          node_id_t;
  typedef logic [$clog2(NUM_DR)-1:0] dr_id_t;
  typedef logic [3:0]                l2_tag_t;
  typedef logic [31:0]               paddr_t;
  typedef logic [63:0]               line_t;
  typedef logic [2:0]                cmd_t;

  // nid and drid lead every packet so the switch finds drid in one place
  typedef struct packed {
    node_id_t nid;
    dr_id_t   drid;
    l2_tag_t  l2id;
    cmd_t     cmd;
    paddr_t   paddr;
  } l2todr_req_t;

  typedef struct packed {
    node_id_t nid;
    dr_id_t   drid;
    l2_tag_t  l2id;
    paddr_t   paddr;
    line_t    line;
  } l2todr_disp_t;

  // nid is the destination L2, drid the sending directory
  typedef struct packed {
    node_id_t nid;
    dr_id_t   drid;
    l2_tag_t  l2id;
    paddr_t   paddr;
    line_t    line;
  } drtol2_snack_t;

endpackage

`default_nettype wire

//--- net_rr_arbiter.sv
// round-robin grant for requesters competing for one destination
// grant is combinational, the pointer moves past the winner on advance
`default_nettype none
`timescale 1ns/10ps

module net_rr_arbiter #(
  parameter int N = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [N-1:0] req,
  input  logic         advance,  // granted packet moved this edge
  output logic [N-1:0] grant
);

  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  ptr_t ptr;       // highest priority requester
  ptr_t win_idx;
  ptr_t next_ptr;

  // first active request at or after ptr, wrapping
  always_comb begin
    int   idx;
    logic found;
    grant   = '0;
    win_idx = ptr;
    found   = 1'b0;
    for (int k = 0; k < N; k++) begin
      idx = int'(ptr) + k;
      if (idx >= N) idx = idx - N;
      if (!found && req[idx]) begin
        grant[idx] = 1'b1;
        win_idx    = ptr_t'(idx);
        found      = 1'b1;
      end
    end
  end

  assign next_ptr = (int'(win_idx) == N - 1) ? '0 : win_idx + ptr_t'(1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (advance) begin
      ptr <= next_ptr;  // one past the winner
    end
  end

endmodule

`default_nettype wire

//--- net_out_buffer.sv
// two-entry queue in front of one destination
// writes when in_valid and not full, presents its head while not empty,
// and pops on valid with retry low; push and pop may share a cycle
`default_nettype none
`timescale 1ns/10ps

module net_out_buffer #(
  parameter type pkt_t = net_pkg::l2todr_req_t
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_full,
  input  pkt_t in_pkt,
  output logic out_valid,
  input  logic out_retry,
  output pkt_t out_pkt
);

  pkt_t       mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;   // 0..2 entries
  logic       push;
  logic       pop;

  assign in_full   = (count == 2'd2);
  assign out_valid = (count != 2'd0);
  assign out_pkt   = mem[rd_ptr];  // held stable while retried

  assign push = in_valid && !in_full;
  assign pop  = out_valid && !out_retry;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;  // idle or pass-through
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_pkt;
    end
  end

endmodule

`default_nettype wire

//--- net_l2todr_switch.sv
// routes one L2 to directory channel by the packet's drid
// one arbiter and one output buffer per directory; used for both
// requests and displacements since drid sits at the same spot in both
`default_nettype none
`timescale 1ns/10ps

module net_l2todr_switch #(
  parameter int  NUM_SRC = 4,
  parameter type pkt_t   = net_pkg::l2todr_req_t
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [NUM_SRC-1:0]         src_valid,
  output logic [NUM_SRC-1:0]         src_retry,
  input  pkt_t                       src_pkt [NUM_SRC],
  output logic [net_pkg::NUM_DR-1:0] dr_valid,
  input  logic [net_pkg::NUM_DR-1:0] dr_retry,
  output pkt_t                       dr_pkt [net_pkg::NUM_DR]
);

  import net_pkg::*;

  logic [NUM_SRC-1:0] dr_req   [NUM_DR];
  logic [NUM_SRC-1:0] dr_grant [NUM_DR];
  logic [NUM_DR-1:0]  dr_full;

  // split source valids by target directory
  always_comb begin
    for (int d = 0; d < NUM_DR; d++) begin
      for (int i = 0; i < NUM_SRC; i++) begin
        dr_req[d][i] = src_valid[i] && (src_pkt[i].drid == dr_id_t'(d));
      end
    end
  end

  for (genvar d = 0; d < NUM_DR; d++) begin : g_dr
    logic push;     // winner moves into the buffer
    pkt_t win_pkt;

    assign push = |dr_grant[d] && !dr_full[d];

    always_comb begin
      win_pkt = src_pkt[0];
      for (int i = 0; i < NUM_SRC; i++) begin
        if (dr_grant[d][i]) win_pkt = src_pkt[i];
      end
    end

    net_rr_arbiter #(
      .N(NUM_SRC)
    ) u_arb (
      .clk,
      .rst_n,
      .req     (dr_req[d]),
      .advance (push),
      .grant   (dr_grant[d])
    );

    net_out_buffer #(
      .pkt_t(pkt_t)
    ) u_buf (
      .clk,
      .rst_n,
      .in_valid  (|dr_grant[d]),
      .in_full   (dr_full[d]),
      .in_pkt    (win_pkt),
      .out_valid (dr_valid[d]),
      .out_retry (dr_retry[d]),
      .out_pkt   (dr_pkt[d])
    );
  end

  // a source is released only when it wins at a directory with room
  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      src_retry[i] = 1'b1;
      for (int d = 0; d < NUM_DR; d++) begin
        if (dr_grant[d][i] && !dr_full[d]) src_retry[i] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- net_snack_router.sv
// routes directory snoop/ack responses to the L2 ports by destination nid
// per node a two-way arbiter picks a directory and a buffer drives the L2
`default_nettype none
`timescale 1ns/10ps

module net_snack_router #(
  parameter int NUM_SRC = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [net_pkg::NUM_DR-1:0] dr_valid,
  output logic [net_pkg::NUM_DR-1:0] dr_retry,
  input  net_pkg::drtol2_snack_t     dr_snack [net_pkg::NUM_DR],
  output logic [NUM_SRC-1:0]         l2_valid,
  input  logic [NUM_SRC-1:0]         l2_retry,
  output net_pkg::drtol2_snack_t     l2_snack [NUM_SRC]
);

  import net_pkg::*;

  logic [NUM_DR-1:0]  node_req   [NUM_SRC];
  logic [NUM_DR-1:0]  node_grant [NUM_SRC];
  logic [NUM_SRC-1:0] node_full;

  // nid decode per directory
  always_comb begin
    for (int n = 0; n < NUM_SRC; n++) begin
      for (int d = 0; d < NUM_DR; d++) begin
        node_req[n][d] = dr_valid[d] && (dr_snack[d].nid == node_id_t'(n));
      end
    end
  end

  for (genvar n = 0; n < NUM_SRC; n++) begin : g_node
    logic          push;
    drtol2_snack_t win_snack;

    assign push = |node_grant[n] && !node_full[n];

    always_comb begin
      win_snack = dr_snack[0];
      for (int d = 0; d < NUM_DR; d++) begin
        if (node_grant[n][d]) win_snack = dr_snack[d];
      end
    end

    net_rr_arbiter #(
      .N(NUM_DR)
    ) u_arb (
      .clk,
      .rst_n,
      .req     (node_req[n]),
      .advance (push),
      .grant   (node_grant[n])
    );

    net_out_buffer #(
      .pkt_t(drtol2_snack_t)
    ) u_buf (
      .clk,
      .rst_n,
      .in_valid  (|node_grant[n]),
      .in_full   (node_full[n]),
      .in_pkt    (win_snack),
      .out_valid (l2_valid[n]),
      .out_retry (l2_retry[n]),
      .out_pkt   (l2_snack[n])
    );
  end

  // nid beyond NUM_SRC never wins, so that directory stays in retry
  always_comb begin
    for (int d = 0; d < NUM_DR; d++) begin
      dr_retry[d] = 1'b1;
      for (int n = 0; n < NUM_SRC; n++) begin
        if (node_grant[n][d] && !node_full[n]) dr_retry[d] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- net_2core2dr.sv
// interconnect between the L2 ports of a two-core system and two directories
// requests and displacements go out by drid, snacks come back by nid
// source order is c0 L2I, c0 L2D, c1 L2I, c1 L2D (node id 0..3)
`default_nettype none
`timescale 1ns/10ps

module net_2core2dr #(
  parameter int NUM_SRC = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,

  // requests, L2 side
  input  logic [NUM_SRC-1:0]         l2todr_req_valid,
  output logic [NUM_SRC-1:0]         l2todr_req_retry,
  input  net_pkg::l2todr_req_t       l2todr_req [NUM_SRC],
  // requests, directory side
  output logic [net_pkg::NUM_DR-1:0] dr_req_valid,
  input  logic [net_pkg::NUM_DR-1:0] dr_req_retry,
  output net_pkg::l2todr_req_t       dr_req [net_pkg::NUM_DR],

  // displacements, L2 side
  input  logic [NUM_SRC-1:0]         l2todr_disp_valid,
  output logic [NUM_SRC-1:0]         l2todr_disp_retry,
  input  net_pkg::l2todr_disp_t      l2todr_disp [NUM_SRC],
  // displacements, directory side
  output logic [net_pkg::NUM_DR-1:0] dr_disp_valid,
  input  logic [net_pkg::NUM_DR-1:0] dr_disp_retry,
  output net_pkg::l2todr_disp_t      dr_disp [net_pkg::NUM_DR],

  // snacks, directory side
  input  logic [net_pkg::NUM_DR-1:0] dr_snack_valid,
  output logic [net_pkg::NUM_DR-1:0] dr_snack_retry,
  input  net_pkg::drtol2_snack_t     dr_snack [net_pkg::NUM_DR],
  // snacks, L2 side
  output logic [NUM_SRC-1:0]         l2_snack_valid,
  input  logic [NUM_SRC-1:0]         l2_snack_retry,
  output net_pkg::drtol2_snack_t     l2_snack [NUM_SRC]
);

  // towards directory
  net_l2todr_switch #(
    .NUM_SRC (NUM_SRC),
    .pkt_t   (net_pkg::l2todr_req_t)
  ) u_req_switch (
    .clk,
    .rst_n,
    .src_valid (l2todr_req_valid),
    .src_retry (l2todr_req_retry),
    .src_pkt   (l2todr_req),
    .dr_valid  (dr_req_valid),
    .dr_retry  (dr_req_retry),
    .dr_pkt    (dr_req)
  );

  net_l2todr_switch #(
    .NUM_SRC (NUM_SRC),
    .pkt_t   (net_pkg::l2todr_disp_t)
  ) u_disp_switch (
    .clk,
    .rst_n,
    .src_valid (l2todr_disp_valid),
    .src_retry (l2todr_disp_retry),
    .src_pkt   (l2todr_disp),
    .dr_valid  (dr_disp_valid),
    .dr_retry  (dr_disp_retry),
    .dr_pkt    (dr_disp)
  );

  // towards L2
  net_snack_router #(
    .NUM_SRC(NUM_SRC)
  ) u_snack_router (
    .clk,
    .rst_n,
    .dr_valid (dr_snack_valid),
    .dr_retry (dr_snack_retry),
    .dr_snack (dr_snack),
    .l2_valid (l2_snack_valid),
    .l2_retry (l2_snack_retry),
    .l2_snack (l2_snack)
  );

endmodule

`default_nettype wire

//--- tb_net_2core2dr.sv
// self-checking random testbench for the L2 to directory network
// a scoreboard keeps one queue per source/destination pair and compares
// every packet that leaves the DUT; build and run with make run
`default_nettype none
`timescale 1ns/10ps

module tb_net_2core2dr;

  import net_pkg::*;

  localparam int NUM_SRC      = 4;
  localparam int CLK_PERIOD   = 8;
  localparam int RST_CYCLES   = 3;
  localparam int ROT_CYCLES   = 12;
  localparam int STALL_CYCLES = 100;
  localparam int RAND_CYCLES  = 2000;
  localparam int DRAIN_CYCLES = 200;
  localparam int RUN_CYCLES   =
    RST_CYCLES + 2 + ROT_CYCLES + STALL_CYCLES + RAND_CYCLES + DRAIN_CYCLES;
  localparam int WATCHDOG_NS  = RUN_CYCLES * CLK_PERIOD + 400;

  localparam int MODE_IDLE   = 0;  // drain, no new packets
  localparam int MODE_ROTATE = 1;  // all sources to dir 0, no retry
  localparam int MODE_STALL  = 2;  // dir 1 held in retry
  localparam int MODE_RANDOM = 3;

  typedef logic [127:0] cmp_t;

  logic clk;
  logic rst_n;
  int   mode;

  logic [NUM_SRC-1:0] l2todr_req_valid, l2todr_req_retry;
  l2todr_req_t        l2todr_req [NUM_SRC];
  logic [NUM_DR-1:0]  dr_req_valid, dr_req_retry;
  l2todr_req_t        dr_req [NUM_DR];
  logic [NUM_SRC-1:0] l2todr_disp_valid, l2todr_disp_retry;
  l2todr_disp_t       l2todr_disp [NUM_SRC];
  logic [NUM_DR-1:0]  dr_disp_valid, dr_disp_retry;
  l2todr_disp_t       dr_disp [NUM_DR];
  logic [NUM_DR-1:0]  dr_snack_valid, dr_snack_retry;
  drtol2_snack_t      dr_snack [NUM_DR];
  logic [NUM_SRC-1:0] l2_snack_valid, l2_snack_retry;
  drtol2_snack_t      l2_snack [NUM_SRC];

  // scoreboard, index src*NUM_DR+dr for req/disp and dr*NUM_SRC+node for snack
  l2todr_req_t   req_q   [NUM_SRC*NUM_DR][$];
  l2todr_disp_t  disp_q  [NUM_SRC*NUM_DR][$];
  drtol2_snack_t snack_q [NUM_SRC*NUM_DR][$];
  int            rot_order[$];  // accepted sources in rotate mode
  int            stall_dr0_acc, stall_req_acc, stall_disp_acc;

  // last sampled destination state, for the hold check
  logic [NUM_DR-1:0]  hold_req_v, hold_req_r, hold_disp_v, hold_disp_r;
  l2todr_req_t        hold_req_p [NUM_DR];
  l2todr_disp_t       hold_disp_p [NUM_DR];
  logic [NUM_SRC-1:0] hold_snack_v, hold_snack_r;
  drtol2_snack_t      hold_snack_p [NUM_SRC];

  net_2core2dr #(
    .NUM_SRC(NUM_SRC)
  ) u_net_2core2dr (
    .clk               (clk),
    .rst_n             (rst_n),
    .l2todr_req_valid  (l2todr_req_valid),
    .l2todr_req_retry  (l2todr_req_retry),
    .l2todr_req        (l2todr_req),
    .dr_req_valid      (dr_req_valid),
    .dr_req_retry      (dr_req_retry),
    .dr_req            (dr_req),
    .l2todr_disp_valid (l2todr_disp_valid),
    .l2todr_disp_retry (l2todr_disp_retry),
    .l2todr_disp       (l2todr_disp),
    .dr_disp_valid     (dr_disp_valid),
    .dr_disp_retry     (dr_disp_retry),
    .dr_disp           (dr_disp),
    .dr_snack_valid    (dr_snack_valid),
    .dr_snack_retry    (dr_snack_retry),
    .dr_snack          (dr_snack),
    .l2_snack_valid    (l2_snack_valid),
    .l2_snack_retry    (l2_snack_retry),
    .l2_snack          (l2_snack)
  );

  task automatic check(input string name, input cmp_t exp, input cmp_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // a retried output must keep valid and packet until it moves
  task automatic check_hold(input string name, input logic pv, input logic pr,
                            input cmp_t pp, input logic cv, input cmp_t cp);
    if (pv && pr) begin
      check({name, " valid held under retry"}, cmp_t'(1'b1), cmp_t'(cv));
      check({name, " packet held under retry"}, pp, cp);
    end
  endtask

  // reference arbitration: first requester at or after ptr, wrapping
  function automatic int rr_pick(int ptr, logic [NUM_SRC-1:0] mask);
    int idx;
    for (int k = 0; k < NUM_SRC; k++) begin
      idx = (ptr + k) % NUM_SRC;
      if (mask[idx]) return idx;
    end
    return ptr;
  endfunction

  function automatic logic chance(int pct);
    return ($urandom % 100) < pct;
  endfunction

  function automatic logic pick_valid(int m, logic req_chan);
    case (m)
      MODE_ROTATE: return req_chan;
      MODE_STALL, MODE_RANDOM: return chance(50);
      default: return 1'b0;
    endcase
  endfunction

  function automatic dr_id_t pick_drid(int m, int src);
    case (m)
      MODE_ROTATE: return '0;
      MODE_STALL:  return dr_id_t'(src >= 2);  // sources 2,3 aim at the stalled dir
      default:     return dr_id_t'($urandom);
    endcase
  endfunction

  function automatic logic pick_noise(int m);
    return (m == MODE_STALL || m == MODE_RANDOM) ? chance(30) : 1'b0;
  endfunction

  function automatic l2todr_req_t make_req(int src, dr_id_t drid);
    l2todr_req_t p;
    p.nid   = node_id_t'(src);
    p.drid  = drid;
    p.l2id  = l2_tag_t'($urandom);
    p.cmd   = cmd_t'($urandom);
    p.paddr = $urandom;
    return p;
  endfunction

  function automatic l2todr_disp_t make_disp(int src, dr_id_t drid);
    l2todr_disp_t p;
    p.nid   = node_id_t'(src);
    p.drid  = drid;
    p.l2id  = l2_tag_t'($urandom);
    p.paddr = $urandom;
    p.line  = {$urandom, $urandom};
    return p;
  endfunction

  function automatic drtol2_snack_t make_snack(int dr);
    drtol2_snack_t p;
    p.nid   = node_id_t'($urandom % NUM_SRC);
    p.drid  = dr_id_t'(dr);
    p.l2id  = l2_tag_t'($urandom);
    p.paddr = $urandom;
    p.line  = {$urandom, $urandom};
    return p;
  endfunction

  function automatic logic model_empty();
    for (int k = 0; k < NUM_SRC*NUM_DR; k++) begin
      if (req_q[k].size() != 0 || disp_q[k].size() != 0 || snack_q[k].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("run timed out before all packets were delivered");
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  // stimulus, new packet only once the previous one moved
  always @(posedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < NUM_SRC; i++) begin
        if (!l2todr_req_valid[i] || !l2todr_req_retry[i]) begin
          l2todr_req_valid[i] <= pick_valid(mode, 1'b1);
          l2todr_req[i]       <= make_req(i, pick_drid(mode, i));
        end
        if (!l2todr_disp_valid[i] || !l2todr_disp_retry[i]) begin
          l2todr_disp_valid[i] <= pick_valid(mode, 1'b0);
          l2todr_disp[i]       <= make_disp(i, pick_drid(mode, i));
        end
        l2_snack_retry[i] <= pick_noise(mode);
      end
      for (int d = 0; d < NUM_DR; d++) begin
        if (!dr_snack_valid[d] || !dr_snack_retry[d]) begin
          dr_snack_valid[d] <= (mode == MODE_STALL || mode == MODE_RANDOM) && chance(50);
          dr_snack[d]       <= make_snack(d);
        end
        dr_req_retry[d]  <= (mode == MODE_STALL) ? (d == 1) : pick_noise(mode);
        dr_disp_retry[d] <= (mode == MODE_STALL) ? (d == 1) : pick_noise(mode);
      end
    end
  end

  // scoreboard, pushes on source transfers and compares on destination ones
  always @(posedge clk) begin
    int qi;
    if (rst_n) begin
      for (int i = 0; i < NUM_SRC; i++) begin
        if (l2todr_req_valid[i] && !l2todr_req_retry[i]) begin
          qi = i*NUM_DR + int'(l2todr_req[i].drid);
          req_q[qi].push_back(l2todr_req[i]);
          if (mode == MODE_ROTATE) rot_order.push_back(i);
          if (mode == MODE_STALL) begin
            if (l2todr_req[i].drid == 1'b1) stall_req_acc++;
            else if (stall_req_acc == 2) stall_dr0_acc++;  // dir1 buffer already full
          end
        end
        if (l2todr_disp_valid[i] && !l2todr_disp_retry[i]) begin
          qi = i*NUM_DR + int'(l2todr_disp[i].drid);
          disp_q[qi].push_back(l2todr_disp[i]);
          if (mode == MODE_STALL) begin
            if (l2todr_disp[i].drid == 1'b1) stall_disp_acc++;
            else if (stall_disp_acc == 2) stall_dr0_acc++;
          end
        end
      end
      for (int d = 0; d < NUM_DR; d++) begin
        if (dr_snack_valid[d] && !dr_snack_retry[d]) begin
          snack_q[d*NUM_SRC + int'(dr_snack[d].nid)].push_back(dr_snack[d]);
        end
      end
      for (int d = 0; d < NUM_DR; d++) begin
        check_hold($sformatf("req dir%0d", d), hold_req_v[d], hold_req_r[d],
                   cmp_t'(hold_req_p[d]), dr_req_valid[d], cmp_t'(dr_req[d]));
        check_hold($sformatf("disp dir%0d", d), hold_disp_v[d], hold_disp_r[d],
                   cmp_t'(hold_disp_p[d]), dr_disp_valid[d], cmp_t'(dr_disp[d]));
        if (dr_req_valid[d] && !dr_req_retry[d]) begin
          qi = int'(dr_req[d].nid)*NUM_DR + d;
          check($sformatf("req dir%0d has an accepted packet", d), cmp_t'(1'b1),
                cmp_t'(req_q[qi].size() != 0));
          check($sformatf("req dir%0d contents", d), cmp_t'(req_q[qi][0]), cmp_t'(dr_req[d]));
          void'(req_q[qi].pop_front());
        end
        if (dr_disp_valid[d] && !dr_disp_retry[d]) begin
          qi = int'(dr_disp[d].nid)*NUM_DR + d;
          check($sformatf("disp dir%0d has an accepted packet", d), cmp_t'(1'b1),
                cmp_t'(disp_q[qi].size() != 0));
          check($sformatf("disp dir%0d contents", d), cmp_t'(disp_q[qi][0]),
                cmp_t'(dr_disp[d]));
          void'(disp_q[qi].pop_front());
        end
      end
      for (int n = 0; n < NUM_SRC; n++) begin
        check_hold($sformatf("snack l2 %0d", n), hold_snack_v[n], hold_snack_r[n],
                   cmp_t'(hold_snack_p[n]), l2_snack_valid[n], cmp_t'(l2_snack[n]));
        if (l2_snack_valid[n] && !l2_snack_retry[n]) begin
          qi = int'(l2_snack[n].drid)*NUM_SRC + n;
          check($sformatf("snack l2 %0d has an accepted packet", n), cmp_t'(1'b1),
                cmp_t'(snack_q[qi].size() != 0));
          check($sformatf("snack l2 %0d contents", n), cmp_t'(snack_q[qi][0]),
                cmp_t'(l2_snack[n]));
          void'(snack_q[qi].pop_front());
        end
      end
    end
    hold_req_v   = dr_req_valid;
    hold_req_r   = dr_req_retry;
    hold_req_p   = dr_req;
    hold_disp_v  = dr_disp_valid;
    hold_disp_r  = dr_disp_retry;
    hold_disp_p  = dr_disp;
    hold_snack_v = l2_snack_valid;
    hold_snack_r = l2_snack_retry;
    hold_snack_p = l2_snack;
  end

  initial begin
    int ptr;
    int exp_src;
    void'($urandom(23));
    mode     = MODE_IDLE;
    rst_n    = 1'b0;
    l2todr_req_valid  = '0;
    l2todr_disp_valid = '0;
    dr_req_retry      = '0;
    dr_disp_retry     = '0;
    dr_snack_valid    = '0;
    l2_snack_retry    = '0;
    for (int i = 0; i < NUM_SRC; i++) begin
      l2todr_req[i]  = '0;
      l2todr_disp[i] = '0;
    end
    for (int d = 0; d < NUM_DR; d++) begin
      dr_snack[d] = '0;
    end
    stall_dr0_acc  = 0;
    stall_req_acc  = 0;
    stall_disp_acc = 0;

    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("destination valids after reset", '0,
          cmp_t'({dr_req_valid, dr_disp_valid, l2_snack_valid}));

    @(posedge clk);
    mode <= MODE_ROTATE;
    repeat (ROT_CYCLES) @(posedge clk);
    mode <= MODE_STALL;
    @(negedge clk);
    check("rotation sample count", cmp_t'(1'b1), cmp_t'(rot_order.size() >= 5));
    ptr = 0;
    for (int k = 0; k < rot_order.size(); k++) begin
      exp_src = rr_pick(ptr, '1);
      check($sformatf("rotation grant %0d", k), cmp_t'(exp_src), cmp_t'(rot_order[k]));
      ptr = (exp_src + 1) % NUM_SRC;
    end

    repeat (STALL_CYCLES) @(posedge clk);
    mode <= MODE_RANDOM;
    @(negedge clk);
    check("dir0 accepts while dir1 buffer full", cmp_t'(1'b1), cmp_t'(stall_dr0_acc > 0));
    check("stalled dir1 req fills two-entry buffer", cmp_t'(2), cmp_t'(stall_req_acc));
    check("stalled dir1 disp fills two-entry buffer", cmp_t'(2), cmp_t'(stall_disp_acc));

    repeat (RAND_CYCLES) @(posedge clk);
    mode <= MODE_IDLE;
    @(negedge clk);
    while (!model_empty() || (|l2todr_req_valid) || (|l2todr_disp_valid) ||
           (|dr_snack_valid)) begin
      @(negedge clk);
    end
    // nothing left inside the DUT once every accepted packet came out
    check("destination valids idle at end", '0,
          cmp_t'({dr_req_valid, dr_disp_valid, l2_snack_valid}));
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
net_pkg.sv
net_rr_arbiter.sv
net_out_buffer.sv
net_l2todr_switch.sv
net_snack_router.sv
net_2core2dr.sv
tb_net_2core2dr.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_net_2core2dr
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the testbench prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
